// ==== common/ifetch_pkg.sv ====
// Sv32 widths with 4 KB pages; physical addresses are cut to the fetch memory size, so upper bits alias
package ifetch_pkg;

    // data and virtual address width
    localparam int xlen = 32;

    // Sv32 address split
    localparam int page_offset_bits = 12;
    localparam int vpn_bits = 10;
    localparam int pte_size_bits = 2;

    // PTE fields, D A G U X W R V in the low byte
    localparam int pte_r_bit = 1;
    localparam int pte_x_bit = 3;
    localparam int pte_ppn0_lsb = 10;
    localparam int pte_ppn1_lsb = 20;

    // satp fields
    localparam int asid_bits = 9;
    localparam int satp_ppn_bits = 22;

    // fetch memory geometry
    localparam int mem_addr_bits = 12;
    localparam int mem_words = 2 ** mem_addr_bits;
    localparam int word_offset_bits = 2;

    // sequential fetch step
    localparam int inst_bytes = 4;

    // RISC-V privilege encodings
    typedef enum logic [1:0] {
        u_mode = 2'b00,
        s_mode = 2'b01,
        m_mode = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        idle,
        walk_ready,
        walk_valid,
        if_ready,
        if_valid,
        if_end
    } walk_state_e;

    typedef struct packed {
        logic                     mode;
        logic [asid_bits-1:0]     asid;
        logic [satp_ppn_bits-1:0] ppn;
    } satp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] inst;
    } fetch_resp_t;

    // load port, byte address
    typedef struct packed {
        logic            en;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_out_t;

endpackage

// ==== logic/fetch_mem.sv ====
// single read port always ready with one-cycle latency; writes are for loading only and must not overlap reads
module fetch_mem
    import ifetch_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  fetch_req_t  memreq,
    output logic        memreq_ready,
    output fetch_resp_t memresp,
    input  mem_wr_t     mem_wr
);

    logic [xlen-1:0] mem [mem_words];

    // word indices, upper byte address bits alias
    logic [mem_addr_bits-1:0] rd_idx;
    logic [mem_addr_bits-1:0] wr_idx;

    logic            rd_fire;
    logic            rd_valid_q;
    logic [xlen-1:0] rd_addr_q;
    logic [xlen-1:0] rd_data_q;

    // never stalls
    assign memreq_ready = 1'b1;

    assign rd_fire = memreq.valid && memreq_ready;
    assign rd_idx  = memreq.addr[word_offset_bits +: mem_addr_bits];
    assign wr_idx  = mem_wr.addr[word_offset_bits +: mem_addr_bits];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem[wr_idx] <= mem_wr.data;
        end
        if (rd_fire) begin
            rd_data_q <= mem[rd_idx];
            // echo so the walker can pair the word with its request
            rd_addr_q <= memreq.addr;
        end
    end

    assign memresp.valid = rd_valid_q;
    assign memresp.addr  = rd_addr_q;
    assign memresp.inst  = rd_data_q;

    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_wr.en && memreq.valid)
    ) else $error("memory load write collides with a fetch read");

endmodule

// ==== page_walker/page_walker.sv ====
// no TLB and no page faults; every translated fetch walks from the root and V/U/A/D bits are not checked
module page_walker
    import ifetch_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  fetch_req_t  ireq,
    output logic        ireq_ready,
    output fetch_resp_t iresp,
    output fetch_req_t  memreq,
    input  logic        memreq_ready,
    input  fetch_resp_t memresp,
    input  priv_mode_e  csr_mode,
    input  satp_t       csr_satp,
    input  logic        kill
);

    walk_state_e state;

    // current page table level, counts down from 1
    logic [1:0] level;
    logic       resp_valid_q;

    // latched virtual address, next memory address, fetched word
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] next_addr;
    logic [xlen-1:0] result_inst;

    logic sv32_en;
    logic advance;
    logic pte_leaf;
    logic walk_done;

    logic [vpn_bits-1:0]         vpn1_in;
    logic [vpn_bits-1:0]         vpn0;
    logic [page_offset_bits-1:0] page_off;

    // full 34-bit Sv32 physical addresses before the cut
    logic [xlen+1:0] root_pte_pa;
    logic [xlen+1:0] l0_pte_pa;
    logic [xlen+1:0] leaf_pa;

    fetch_req_t  sv32_req;
    fetch_resp_t sv32_resp;

    assign sv32_en = (csr_mode != m_mode) && csr_satp.mode;
    assign advance = sv32_en && !kill;

    // vpn1 comes straight from ireq while idle
    assign vpn1_in  = ireq.addr[xlen-1 -: vpn_bits];
    assign vpn0     = req_addr[page_offset_bits +: vpn_bits];
    assign page_off = req_addr[page_offset_bits-1:0];

    assign pte_leaf  = memresp.inst[pte_r_bit] || memresp.inst[pte_x_bit];
    assign walk_done = (level == 2'b11) || pte_leaf;

    assign root_pte_pa = {csr_satp.ppn, vpn1_in, {pte_size_bits{1'b0}}};
    assign l0_pte_pa   = {memresp.inst[xlen-1:pte_ppn0_lsb], vpn0, {pte_size_bits{1'b0}}};

    always_comb begin
        case (level)
            // megapage
            2'b01: leaf_pa = {memresp.inst[xlen-1:pte_ppn1_lsb], vpn0, page_off};
            2'b00: leaf_pa = {memresp.inst[xlen-1:pte_ppn1_lsb],
                              memresp.inst[pte_ppn1_lsb-1:pte_ppn0_lsb], page_off};
            // walked past level 0, undefined, fetch from 0
            default: leaf_pa = '0;
        endcase
    end

    assign sv32_req.valid  = (state == walk_ready) || (state == if_ready);
    assign sv32_req.addr   = next_addr;
    assign sv32_resp.valid = resp_valid_q;
    assign sv32_resp.addr  = req_addr;
    assign sv32_resp.inst  = result_inst;

    // bare mode is pure wiring between fetch side and memory
    assign ireq_ready = sv32_en ? (state == idle) : memreq_ready;
    assign memreq     = sv32_en ? sv32_req : ireq;
    assign iresp      = sv32_en ? sv32_resp : memresp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= idle;
            level        <= 2'b01;
            resp_valid_q <= 1'b0;
        end else if (kill) begin
            state        <= idle;
            resp_valid_q <= 1'b0;
        end else begin
            // response leaves from a flop the cycle after if_end
            resp_valid_q <= sv32_en && (state == if_end);
            if (sv32_en) begin
                case (state)
                    idle: begin
                        if (ireq.valid) begin
                            state <= walk_ready;
                            level <= 2'b01;
                        end
                    end
                    walk_ready: begin
                        if (sv32_req.valid && memreq_ready) begin
                            state <= walk_valid;
                        end
                    end
                    walk_valid: begin
                        if (memresp.valid) begin
                            if (walk_done) begin
                                state <= if_ready;
                            end else begin
                                level <= level - 2'd1;
                                state <= walk_ready;
                            end
                        end
                    end
                    if_ready: begin
                        if (sv32_req.valid && memreq_ready) begin
                            state <= if_valid;
                        end
                    end
                    if_valid: begin
                        if (memresp.valid) begin
                            state <= if_end;
                        end
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && state == idle && ireq.valid) begin
            req_addr  <= ireq.addr;
            next_addr <= root_pte_pa[xlen-1:0];
        end
        if (advance && state == walk_valid && memresp.valid) begin
            next_addr <= walk_done ? leaf_pa[xlen-1:0] : l0_pte_pa[xlen-1:0];
        end
        if (advance && state == if_valid && memresp.valid) begin
            result_inst <= memresp.inst;
        end
    end

    // a pending memory request is held until the memory takes it
    a_memreq_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        memreq.valid && !memreq_ready && !kill |=> memreq.valid
    ) else $error("memreq dropped before acceptance");

    a_level_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == walk_valid |-> level != 2'b10
    ) else $error("walker level reached 2'b10");

    a_iresp_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        sv32_en && iresp.valid |=> !iresp.valid
    ) else $error("translated iresp held for two cycles");

endmodule

// ==== logic/fetch_sequencer.sv ====
// one fetch in flight at a time; stays stopped after reset until the first redirect
module fetch_sequencer
    import ifetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,
    output fetch_req_t      ireq,
    input  logic            ireq_ready,
    input  fetch_resp_t     iresp,
    output logic            kill,
    output fetch_out_t      fetch_out
);

    logic running_q;
    // fetch accepted, response not yet seen
    logic busy_q;

    logic [xlen-1:0] pc_q;

    logic            out_valid_q;
    logic [xlen-1:0] out_pc_q;
    logic [xlen-1:0] out_inst_q;

    logic issue;
    logic deliver;

    assign kill = redirect_valid;

    // no new request in the redirect cycle, the old pc is dead
    assign ireq.valid = running_q && !busy_q && !redirect_valid;
    assign ireq.addr  = pc_q;

    assign issue   = ireq.valid && ireq_ready;
    assign deliver = iresp.valid && busy_q && !redirect_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running_q   <= 1'b0;
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= deliver;
            if (redirect_valid) begin
                running_q <= 1'b1;
                busy_q    <= 1'b0;
            end else if (issue) begin
                busy_q <= 1'b1;
            end else if (deliver) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            pc_q <= redirect_pc;
        end else if (deliver) begin
            pc_q <= pc_q + xlen'(inst_bytes);
        end
        if (deliver) begin
            out_pc_q   <= pc_q;
            out_inst_q <= iresp.inst;
        end
    end

    assign fetch_out.valid = out_valid_q;
    assign fetch_out.pc    = out_pc_q;
    assign fetch_out.inst  = out_inst_q;

    // walker and memory must not produce unsolicited responses
    a_iresp_expected: assert property (
        @(posedge clk) disable iff (!arst_n)
        iresp.valid && !kill |-> busy_q
    ) else $error("iresp with no fetch outstanding");

endmodule

// ==== logic/ifetch_top.sv ====
// instruction fetch with Sv32 walk; memory writes are for loading and must not overlap running fetches
module ifetch_top
    import ifetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  priv_mode_e      csr_mode,
    input  satp_t           csr_satp,
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,
    input  mem_wr_t         mem_wr,
    output fetch_out_t      fetch_out
);

    // sequencer to walker
    fetch_req_t  ireq;
    logic        ireq_ready;
    fetch_resp_t iresp;
    logic        kill;

    // walker to memory
    fetch_req_t  memreq;
    logic        memreq_ready;
    fetch_resp_t memresp;

    fetch_sequencer u_seq (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ireq           (ireq),
        .ireq_ready     (ireq_ready),
        .iresp          (iresp),
        .kill           (kill),
        .fetch_out      (fetch_out)
    );

    page_walker u_walker (
        .clk          (clk),
        .arst_n       (arst_n),
        .ireq         (ireq),
        .ireq_ready   (ireq_ready),
        .iresp        (iresp),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .csr_mode     (csr_mode),
        .csr_satp     (csr_satp),
        .kill         (kill)
    );

    fetch_mem u_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .mem_wr       (mem_wr)
    );

endmodule

// ==== verification/clock_gen.sv ====
// free-running 10 ns clock; reset is held low for 4 rising edges, then released 1 ns after the last one
module clock_gen (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 5;
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release away from the clock edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

// ==== verification/ifetch_tb.sv ====
// memory is loaded once before the first redirect, since the sequencer never stops after that
module ifetch_tb
    import ifetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // about 20 load cycles plus 30 fetches of at most 9 cycles, with a wide margin
    localparam int max_cycles = 2000;
    localparam logic [xlen-1:0] rng_seed = 32'd87;

    // walker latencies from ireq acceptance to iresp, plus one cycle to reissue
    localparam int page_walk_cycles = 8;
    localparam int mega_walk_cycles = 6;

    localparam logic [xlen-1:0] bare_pc = 32'h0000_0100;
    localparam logic [xlen-1:0] mach_pc = 32'h0000_0200;
    localparam logic [xlen-1:0] mega_pc = 32'h0040_2300;
    localparam logic [xlen-1:0] page_pc = 32'h0080_5ff8;

    // root table in frame 1, level-0 table in frame 3
    localparam satp_t bare_satp = '{mode: 1'b0, asid: 9'd0, ppn: 22'd1};
    localparam satp_t sv32_satp = '{mode: 1'b1, asid: 9'd0, ppn: 22'd1};

    logic            clk;
    logic            arst_n;
    priv_mode_e      csr_mode;
    satp_t           csr_satp;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    mem_wr_t         mem_wr;
    fetch_out_t      fetch_out;

    // reference copy of everything loaded into the fetch memory
    logic [xlen-1:0] model_mem [mem_words];
    logic [xlen-1:0] rng_state;
    logic [xlen-1:0] last_mem_addr;
    int unsigned     cycle_count = 0;
    int unsigned     pass_count = 0;
    int unsigned     fail_count = 0;

    clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ifetch_top u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .csr_mode       (csr_mode),
        .csr_satp       (csr_satp),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mem_wr         (mem_wr),
        .fetch_out      (fetch_out)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // address of the last read the memory accepted
    always @(negedge clk) begin
        if (u_dut.memreq.valid && u_dut.memreq_ready) begin
            last_mem_addr = u_dut.memreq.addr;
        end
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(negedge clk);
        end
        $display("Timeout: no end of tests after %0d cycles", cycle_count);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [xlen-1:0] xorshift(input logic [xlen-1:0] s);
        logic [xlen-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // low bits of a 34-bit physical address pick the word
    function automatic logic [mem_addr_bits-1:0] word_index(input logic [xlen+1:0] pa);
        return pa[2 +: mem_addr_bits];
    endfunction

    function automatic logic [xlen-1:0] make_pte(input logic [21:0] ppn, input logic [9:0] flags);
        return {ppn, flags};
    endfunction

    // Sv32 walk over the reference memory
    function automatic logic [xlen+1:0] translate(input logic [xlen-1:0] va, input satp_t satp);
        logic [xlen+1:0] pte_pa;
        logic [xlen-1:0] pte;
        pte_pa = {satp.ppn, va[31:22], 2'b00};
        pte = model_mem[word_index(pte_pa)];
        // R or X at level 1 means a megapage
        if (pte[1] || pte[3]) begin
            return {pte[31:20], va[21:12], va[11:0]};
        end
        pte_pa = {pte[31:10], va[21:12], 2'b00};
        pte = model_mem[word_index(pte_pa)];
        return {pte[31:20], pte[19:10], va[11:0]};
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic load_word(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        mem_wr = '{en: 1'b1, addr: addr, data: data};
        model_mem[word_index({2'b00, addr})] = data;
        next_edge();
        mem_wr.en = 1'b0;
    endtask

    task automatic load_code(input logic [xlen-1:0] pa, input int count);
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift(rng_state);
            load_word(pa + 32'(4 * i), rng_state);
        end
    endtask

    task automatic load_memory();
        load_code(32'h0000_0100, 4);
        load_code(32'h0000_0200, 4);
        // vpn1 1 is a megapage whose ppn1 aliases away above 16 KB
        load_word(32'h0000_1004, make_pte(22'h001400, 10'h009));
        // vpn1 2 points to the level-0 table in frame 3
        load_word(32'h0000_1008, make_pte(22'h000003, 10'h001));
        // vpn0 5 and 6 land in frames 2 and 0, both through aliasing
        load_word(32'h0000_3014, make_pte(22'h000402, 10'h009));
        load_word(32'h0000_3018, make_pte(22'h000c00, 10'h009));
        load_code(32'h0000_2300, 4);
        load_code(32'h0000_2ff8, 2);
        load_code(32'h0000_0000, 2);
    endtask

    // CSRs change in the redirect cycle, so kill clears the old walk
    task automatic start_fetch(input priv_mode_e mode, input satp_t satp,
                               input logic [xlen-1:0] pc);
        csr_mode       = mode;
        csr_satp       = satp;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        next_edge();
        redirect_valid = 1'b0;
    endtask

    task automatic wait_fetch(output fetch_out_t got, output int unsigned at_cycle);
        do begin
            next_edge();
        end while (fetch_out.valid !== 1'b1);
        got      = fetch_out;
        at_cycle = cycle_count;
    endtask

    task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
        logic ok;
        ok = 1'b1;
        if (got.pc !== exp.pc) begin
            $display("Error at %0t: fetch_out.pc expected %h got %h", $time, exp.pc, got.pc);
            ok = 1'b0;
        end
        if (got.inst !== exp.inst) begin
            $display("Error at %0t: fetch_out.inst expected %h got %h",
                     $time, exp.inst, got.inst);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic check_phys(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: memreq.addr expected %h got %h", $time, exp, got);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_gap(input int unsigned got, input int unsigned exp);
        if (got != exp) begin
            $display("Error at %0t: fetch_out.valid spacing expected %0d got %0d",
                     $time, exp, got);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic fetch_and_check(input logic [xlen-1:0] start_pc, input int count,
                                   input logic translated);
        fetch_out_t      got;
        fetch_out_t      exp;
        logic [xlen-1:0] va;
        logic [xlen+1:0] pa;
        int unsigned     at;
        for (int i = 0; i < count; i++) begin
            va = start_pc + 32'(4 * i);
            wait_fetch(got, at);
            pa  = translated ? translate(va, csr_satp) : {2'b00, va};
            exp = '{valid: 1'b1, pc: va, inst: model_mem[word_index(pa)]};
            check_fetch(got, exp);
            check_phys(last_mem_addr, pa[xlen-1:0]);
        end
    endtask

    task automatic report_test(input string name, input int unsigned fails_before);
        if (fail_count == fails_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d errors", name, fail_count - fails_before);
        end
    endtask

    task automatic test_bare();
        int unsigned fails;
        fails = fail_count;
        start_fetch(s_mode, bare_satp, bare_pc);
        fetch_and_check(bare_pc, 4, 1'b0);
        report_test("bare", fails);
    endtask

    task automatic test_machine();
        int unsigned fails;
        fails = fail_count;
        start_fetch(m_mode, sv32_satp, mach_pc);
        fetch_and_check(mach_pc, 4, 1'b0);
        report_test("machine", fails);
    endtask

    task automatic test_megapage();
        int unsigned fails;
        fails = fail_count;
        start_fetch(s_mode, sv32_satp, mega_pc);
        fetch_and_check(mega_pc, 4, 1'b1);
        report_test("megapage", fails);
    endtask

    task automatic test_two_level();
        int unsigned fails;
        fails = fail_count;
        start_fetch(u_mode, sv32_satp, page_pc);
        fetch_and_check(page_pc, 4, 1'b1);
        report_test("two_level", fails);
    endtask

    task automatic test_redirect_walk();
        int unsigned fails;
        fails = fail_count;
        start_fetch(s_mode, sv32_satp, mega_pc);
        // walk is between the root PTE and the instruction read here
        repeat (3) begin
            next_edge();
        end
        start_fetch(s_mode, sv32_satp, page_pc);
        fetch_and_check(page_pc, 1, 1'b1);
        report_test("redirect_walk", fails);
    endtask

    task automatic measure_gap(input logic [xlen-1:0] pc, input int unsigned exp);
        fetch_out_t  first;
        fetch_out_t  second;
        int unsigned c1;
        int unsigned c2;
        start_fetch(s_mode, sv32_satp, pc);
        wait_fetch(first, c1);
        wait_fetch(second, c2);
        check_gap(c2 - c1, exp);
    endtask

    task automatic test_latency();
        int unsigned fails;
        fails = fail_count;
        measure_gap(page_pc, page_walk_cycles + 1);
        measure_gap(mega_pc, mega_walk_cycles + 1);
        report_test("latency", fails);
    endtask

    initial begin
        csr_mode       = m_mode;
        csr_satp       = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        mem_wr         = '0;
        rng_state      = rng_seed;
        @(posedge arst_n);
        next_edge();
        load_memory();
        test_bare();
        test_machine();
        test_megapage();
        test_two_level();
        test_redirect_walk();
        test_latency();
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
common/ifetch_pkg.sv
logic/fetch_mem.sv
page_walker/page_walker.sv
logic/fetch_sequencer.sv
logic/ifetch_top.sv
verification/clock_gen.sv
verification/ifetch_tb.sv
